// File: verilog/div_pkg.sv
// widths and data types of the divider, imported by the datapath, the control and the top level
package div_pkg;

    // operand and result width
    localparam int DATA_W = 32;

    // partial remainder carries one extra sign bit
    localparam int EXT_W = DATA_W + 1;

    // leading-zero counts, round counts and shift amounts, range 0 to 32
    localparam int CNT_W = 6;

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [EXT_W-1:0]  ext_t;
    typedef logic [CNT_W-1:0]  cnt_t;

    // quotient returned for a zero divisor
    localparam data_t ALL_ONES_Q = '1;

endpackage

// File: verilog/srt_ctrl_pkg.sv
// state and quotient-digit encodings of the SRT iteration, imported by control and datapath
package srt_ctrl_pkg;

    // division sequence
    typedef enum logic [1:0] {
        st_idle      = 2'b00,
        st_normalize = 2'b01,
        st_iterate   = 2'b10,
        st_finish    = 2'b11
    } srt_state_e;

    // radix-2 digit set {-1, 0, +1}
    // encoding follows the top two partial remainder bits
    typedef enum logic [1:0] {
        q_zero  = 2'b00,
        q_plus  = 2'b01,
        q_minus = 2'b10
    } qdigit_e;

endpackage

// File: verilog/srt_if.sv
// strobes and status between the divider control and datapath, instanced in the top level
`timescale 1ns/100ps

interface srt_if import div_pkg::*; ();

    // sequencing strobes from the control
    logic load;
    logic normalize;
    logic step;
    logic last;
    logic finish;
    logic special;

    // status from the datapath, valid in the normalize state
    cnt_t rounds;
    logic div_zero;
    logic early_exit;

    modport ctrl (
        output load,
        output normalize,
        output step,
        output last,
        output finish,
        output special,
        input  rounds,
        input  div_zero,
        input  early_exit
    );

    modport dp (
        input  load,
        input  normalize,
        input  step,
        input  last,
        input  finish,
        input  special,
        output rounds,
        output div_zero,
        output early_exit
    );

endinterface

// File: verilog/leading_zero_count.sv
// combinational leading-zero counter, used by the datapath to normalize the operands
`timescale 1ns/100ps

module leading_zero_count import div_pkg::*; (
    input  data_t data,
    output cnt_t  count
);

    logic found;

    // priority search from the msb down
    always_comb begin
        count = cnt_t'(DATA_W);
        found = 1'b0;
        for (int i = DATA_W - 1; i >= 0; i--) begin
            if (!found && data[i]) begin
                count = cnt_t'(DATA_W - 1 - i);
                found = 1'b1;
            end
        end
    end

endmodule

// File: verilog/srt_control.sv
// state machine and round counter that sequence one division through the SRT datapath
`timescale 1ns/100ps

module srt_control import div_pkg::*, srt_ctrl_pkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic div,
    output logic done,
    srt_if.ctrl  bus
);

    srt_state_e state;
    cnt_t       round_cnt;
    logic       is_special;

    // zero divisor or dividend too small, no iteration needed
    assign is_special = bus.div_zero || bus.early_exit;

    // every strobe stalls while div is low
    // no load in the done cycle, a held request restarts one cycle later
    assign bus.load      = div && (state == st_idle) && !done;
    assign bus.normalize = div && (state == st_normalize) && !is_special;
    assign bus.special   = div && (state == st_normalize) && is_special;
    assign bus.step      = div && (state == st_iterate);
    assign bus.last      = bus.step && (round_cnt == '0);
    assign bus.finish    = div && (state == st_finish);

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= st_idle;
            round_cnt <= '0;
            done      <= 1'b0;
        end else begin
            // results land on the same edge
            done <= bus.finish || bus.special;

            case (state)
                st_idle: begin
                    if (bus.load) begin
                        state <= st_normalize;
                    end
                end
                st_normalize: begin
                    if (bus.special) begin
                        state <= st_idle;
                    end else if (bus.normalize) begin
                        // rounds+1 digits in total
                        round_cnt <= bus.rounds;
                        state     <= st_iterate;
                    end
                end
                st_iterate: begin
                    if (bus.last) begin
                        state <= st_finish;
                    end else if (bus.step) begin
                        round_cnt <= round_cnt - cnt_t'(1);
                    end
                end
                st_finish: begin
                    if (bus.finish) begin
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

endmodule

// File: verilog/srt_datapath.sv
// operand registers, normalization, radix-2 SRT iteration and result correction of the divider
`timescale 1ns/100ps

module srt_datapath import div_pkg::*, srt_ctrl_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  div_signed,
    input  data_t dividend,
    input  data_t divisor,
    output data_t quotient,
    output data_t remainder,
    output logic  div_zero_err,
    srt_if.dp     bus
);

    // operand magnitudes and signs
    data_t   x_mag;
    data_t   y_mag;
    logic    x_neg;
    logic    y_neg;

    // captured request
    data_t   x_raw;
    logic    q_sign;
    logic    r_sign;

    // partial remainder, normalized divisor and its negation
    ext_t    rem_reg;
    ext_t    dvs;
    ext_t    ndvs;
    cnt_t    d_shift;

    // positive and negative digit registers
    data_t   pos_q;
    data_t   neg_q;

    cnt_t    s_cnt;
    cnt_t    d_cnt;
    ext_t    dvs_norm;
    qdigit_e digit;
    ext_t    rem_sum;
    ext_t    rem_fix;
    ext_t    rem_shift;
    data_t   q_mag;
    data_t   r_mag;

    assign x_neg = div_signed && dividend[DATA_W-1];
    assign y_neg = div_signed && divisor[DATA_W-1];
    assign x_mag = x_neg ? data_t'(-dividend) : dividend;
    assign y_mag = y_neg ? data_t'(-divisor) : divisor;

    // counts taken on the magnitudes held after load
    leading_zero_count u_lzc_dividend (
        .data  (rem_reg[DATA_W-1:0]),
        .count (s_cnt)
    );

    leading_zero_count u_lzc_divisor (
        .data  (dvs[DATA_W-1:0]),
        .count (d_cnt)
    );

    assign bus.rounds     = d_cnt - s_cnt;
    assign bus.div_zero   = (d_cnt == cnt_t'(DATA_W));
    assign bus.early_exit = bus.rounds[CNT_W-1];

    // divisor msb lands on bit 31
    assign dvs_norm = {1'b0, dvs[DATA_W-1:0] << d_cnt};

    // digit from the top two bits
    always_comb begin
        case (rem_reg[EXT_W-1:EXT_W-2])
            2'b01:   digit = q_plus;
            2'b10:   digit = q_minus;
            default: digit = q_zero;
        endcase
    end

    always_comb begin
        case (digit)
            q_plus:  rem_sum = rem_reg + ndvs;
            q_minus: rem_sum = rem_reg + dvs;
            default: rem_sum = rem_reg;
        endcase
    end

    // negative final remainder takes one divisor back and one off the quotient
    assign rem_fix   = rem_reg[EXT_W-1] ? rem_reg + dvs : rem_reg;
    assign rem_shift = rem_fix >> d_shift;
    assign r_mag     = rem_shift[DATA_W-1:0];
    assign q_mag     = pos_q - neg_q - data_t'(rem_reg[EXT_W-1]);

    always_ff @(posedge clk) begin
        if (bus.load) begin
            x_raw   <= dividend;
            q_sign  <= x_neg ^ y_neg;
            r_sign  <= x_neg;
            rem_reg <= {1'b0, x_mag};
            dvs     <= {1'b0, y_mag};
        end else if (bus.normalize) begin
            rem_reg <= {1'b0, rem_reg[DATA_W-1:0] << s_cnt};
            dvs     <= dvs_norm;
            ndvs    <= -dvs_norm;
            d_shift <= d_cnt;
            pos_q   <= '0;
            neg_q   <= '0;
        end else if (bus.step) begin
            // last step keeps the remainder unshifted
            rem_reg <= bus.last ? rem_sum : rem_sum << 1;
            pos_q   <= {pos_q[DATA_W-2:0], digit == q_plus};
            neg_q   <= {neg_q[DATA_W-2:0], digit == q_minus};
        end
    end

    // results hold until the next completion
    always_ff @(posedge clk) begin
        if (reset) begin
            quotient     <= '0;
            remainder    <= '0;
            div_zero_err <= 1'b0;
        end else if (bus.special) begin
            quotient     <= bus.div_zero ? ALL_ONES_Q : '0;
            remainder    <= x_raw;
            div_zero_err <= bus.div_zero;
        end else if (bus.finish) begin
            quotient     <= q_sign ? -q_mag : q_mag;
            remainder    <= r_sign ? -r_mag : r_mag;
            div_zero_err <= 1'b0;
        end
    end

endmodule

// File: verilog/div_top.sv
// top level of the 32-bit SRT divider with plain ports, quotient or remainder by use_mod
`timescale 1ns/100ps

module div_top import div_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  div,
    input  logic  div_signed,
    input  data_t x,
    input  data_t y,
    input  logic  use_mod,
    output data_t div_result,
    output logic  div_ok,
    output logic  div_zero_err
);

    data_t quotient;
    data_t remainder;
    logic  done;

    srt_if bus ();

    srt_control u_control (
        .clk   (clk),
        .reset (reset),
        .div   (div),
        .done  (done),
        .bus   (bus)
    );

    srt_datapath u_datapath (
        .clk          (clk),
        .reset        (reset),
        .div_signed   (div_signed),
        .dividend     (x),
        .divisor      (y),
        .quotient     (quotient),
        .remainder    (remainder),
        .div_zero_err (div_zero_err),
        .bus          (bus)
    );

    // select works on the held results between requests
    assign div_result = use_mod ? remainder : quotient;

    // idle reads as ok
    assign div_ok = done || !div;

endmodule

// File: tb/div_tb.sv
// self-checking testbench for the divider top level with div_tb as the simulation top
`timescale 1ns/100ps

module div_tb import div_pkg::*; ();

    localparam int NUM_DIRECTED = 17;
    localparam int NUM_RANDOM   = 60;
    localparam int NUM_OPS      = (NUM_DIRECTED + NUM_RANDOM) * 2;
    localparam int CYCLE_LIMIT  = NUM_OPS * 40 + 100;

    logic  clk = 1'b0;
    logic  reset;
    logic  div;
    logic  div_signed;
    data_t x;
    data_t y;
    logic  use_mod;
    data_t div_result;
    logic  div_ok;
    logic  div_zero_err;

    // expected results of the current operand pair
    data_t exp_q;
    data_t exp_r;
    logic  exp_z;
    logic  have_result = 1'b0;

    data_t lfsr = 32'd73;
    int    cycle_cnt = 0;
    int    mismatch_cnt = 0;
    int    timeout_cnt = 0;
    int    done_cnt = 0;

    div_top dut0 (
        .clk          (clk),
        .reset        (reset),
        .div          (div),
        .div_signed   (div_signed),
        .x            (x),
        .y            (y),
        .use_mod      (use_mod),
        .div_result   (div_result),
        .div_ok       (div_ok),
        .div_zero_err (div_zero_err)
    );

    always #10 clk = ~clk;

    // right-shift galois form
    function automatic data_t lfsr_next(input data_t s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic data_t rand_bits(input int n);
        data_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[DATA_W-2:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    // truncating division with the remainder taking the dividend sign
    function automatic void div_ref(input logic sgn, input data_t a, input data_t b,
                                    output data_t q, output data_t r, output logic z);
        logic  a_neg;
        logic  b_neg;
        data_t a_mag;
        data_t b_mag;
        a_neg = sgn && a[DATA_W-1];
        b_neg = sgn && b[DATA_W-1];
        a_mag = a_neg ? -a : a;
        b_mag = b_neg ? -b : b;
        if (b == '0) begin
            q = '1;
            r = a;
            z = 1'b1;
        end else begin
            q = a_mag / b_mag;
            r = a_mag % b_mag;
            q = (a_neg ^ b_neg) ? -q : q;
            r = a_neg ? -r : r;
            z = 1'b0;
        end
    endfunction

    // one request held until completion and then a single idle cycle
    task automatic run_op(input logic sgn, input data_t a, input data_t b, input logic mod);
        data_t q;
        data_t r;
        logic  z;
        div_ref(sgn, a, b, q, r, z);
        div        <= 1'b1;
        div_signed <= sgn;
        x          <= a;
        y          <= b;
        use_mod    <= mod;
        exp_q      <= q;
        exp_r      <= r;
        exp_z      <= z;
        do begin
            @(posedge clk);
        end while (!div_ok);
        div     <= 1'b0;
        use_mod <= !mod;
        @(posedge clk);
    endtask

    task automatic divide_pair(input logic sgn, input data_t a, input data_t b);
        run_op(sgn, a, b, 1'b0);
        run_op(sgn, a, b, 1'b1);
    endtask

    // error counts and verdict
    task automatic report_and_finish();
        $display("errors: %0d mismatch, %0d timeout, %0d completions checked",
                 mismatch_cnt, timeout_cnt, done_cnt);
        if (mismatch_cnt == 0 && timeout_cnt == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("error: timeout, the run exceeded %0d cycles", CYCLE_LIMIT);
            timeout_cnt++;
            report_and_finish();
        end
    end

    // compare at each completion and over the held results while idle
    always @(posedge clk) begin
        if (!reset && div && div_ok) begin
            done_cnt    <= done_cnt + 1;
            have_result <= 1'b1;
            assert (div_result == (use_mod ? exp_r : exp_q)) else begin
                $display("Mismatch div_result: got 0x%h expected 0x%h (x 0x%h y 0x%h)",
                         div_result, use_mod ? exp_r : exp_q, x, y);
                mismatch_cnt++;
            end
            assert (div_zero_err == exp_z) else begin
                $display("Mismatch div_zero_err: got 0x%h expected 0x%h", div_zero_err, exp_z);
                mismatch_cnt++;
            end
        end
        if (!reset && !div) begin
            assert (div_ok) else begin
                $display("Mismatch div_ok: got 0x%h expected 0x1", div_ok);
                mismatch_cnt++;
            end
            if (have_result) begin
                assert (div_result == (use_mod ? exp_r : exp_q)) else begin
                    $display("Mismatch div_result: got 0x%h expected 0x%h while idle",
                             div_result, use_mod ? exp_r : exp_q);
                    mismatch_cnt++;
                end
            end
        end
    end

    initial begin
        logic  sgn;
        data_t a;
        data_t b;
        reset      = 1'b1;
        div        = 1'b0;
        div_signed = 1'b0;
        x          = '0;
        y          = '0;
        use_mod    = 1'b0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);

        // unsigned
        divide_pair(1'b0, 100, 7);
        divide_pair(1'b0, 32'hffff_ffff, 1);
        divide_pair(1'b0, 32'hffff_ffff, 32'hffff_ffff);
        divide_pair(1'b0, 0, 5);
        divide_pair(1'b0, 32'h8000_0000, 3);
        // signed sign combinations and the overflow case
        divide_pair(1'b1, -100, 7);
        divide_pair(1'b1, 100, -7);
        divide_pair(1'b1, -100, -7);
        divide_pair(1'b1, 32'h8000_0000, 32'hffff_ffff);
        divide_pair(1'b1, 32'h8000_0000, 1);
        // zero divisor followed by a normal division that clears the flag
        divide_pair(1'b0, 1234, 0);
        divide_pair(1'b0, 1000, 10);
        divide_pair(1'b1, -5, 0);
        divide_pair(1'b1, 5, -3);
        // dividend magnitude below the divisor
        divide_pair(1'b0, 5, 1000);
        divide_pair(1'b1, -5, 1000);
        divide_pair(1'b1, 3, 32'h8000_0001);

        for (int i = 0; i < NUM_RANDOM; i++) begin
            sgn = 1'(rand_bits(1));
            a   = rand_bits(32);
            // shifted down for small divisor magnitudes
            b   = rand_bits(32) >> rand_bits(5);
            if (rand_bits(1)) begin
                b = -b;
            end
            divide_pair(sgn, a, b);
        end

        // let the last idle check settle
        @(negedge clk);
        report_and_finish();
    end

endmodule

// File: verilog.f
verilog/div_pkg.sv
verilog/srt_ctrl_pkg.sv
verilog/srt_if.sv
verilog/leading_zero_count.sv
verilog/srt_control.sv
verilog/srt_datapath.sv
verilog/div_top.sv
tb/div_tb.sv

// File: Bender.yml
package:
  name: srt_divider

sources:
  - verilog/div_pkg.sv
  - verilog/srt_ctrl_pkg.sv
  - verilog/srt_if.sv
  - verilog/leading_zero_count.sv
  - verilog/srt_control.sv
  - verilog/srt_datapath.sv
  - verilog/div_top.sv
  - target: test
    files:
      - tb/div_tb.sv
